/* source/fp_pkg.sv */
package fp_pkg;

	//////////////////////////////////////////////////////////////////////
	// Single-precision format

	localparam int WORD_W   = 32;
	localparam int EXP_W    = 8;
	localparam int MAN_W    = 23;
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 255;

	// Hidden bit, fraction, then guard, round and sticky
	localparam int SIG_W = 27;

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite register map

	localparam int ADDR_W = 4;

	localparam logic [ADDR_W-1:0] REG_A      = 4'h0;
	localparam logic [ADDR_W-1:0] REG_B      = 4'h4;
	localparam logic [ADDR_W-1:0] REG_CTRL   = 4'h8;
	localparam logic [ADDR_W-1:0] REG_RESULT = 4'hC;

	// Response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* source/fp_align.sv */
`timescale 1ns/1ps

module fp_align import fp_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	input  logic [WORD_W-1:0] in_a,
	input  logic [WORD_W-1:0] in_b,
	output logic             out_valid,
	output logic             out_sign_big,
	output logic             out_sign_small,
	output logic [EXP_W-1:0] out_exp,
	output logic [SIG_W-1:0] out_sig_big,
	output logic [SIG_W-1:0] out_sig_small
);

	logic [EXP_W-1:0]  exp_a;
	logic [EXP_W-1:0]  exp_b;
	logic [SIG_W-1:0]  sig_a;
	logic [SIG_W-1:0]  sig_b;
	logic [WORD_W-2:0] mag_a;
	logic [WORD_W-2:0] mag_b;
	logic              a_big;
	logic [EXP_W-1:0]  exp_big;
	logic [EXP_W-1:0]  exp_small;
	logic [EXP_W-1:0]  exp_diff;
	logic [SIG_W-1:0]  sig_small;
	logic [SIG_W-1:0]  lost_mask;
	logic [SIG_W-1:0]  sig_shifted;

	// Unpack, exponent zero flushes to a zero significand
	assign exp_a = in_a[WORD_W-2 -: EXP_W];
	assign exp_b = in_b[WORD_W-2 -: EXP_W];
	assign sig_a = (exp_a == '0) ? '0 : {1'b1, in_a[MAN_W-1:0], {(SIG_W-MAN_W-1){1'b0}}};
	assign sig_b = (exp_b == '0) ? '0 : {1'b1, in_b[MAN_W-1:0], {(SIG_W-MAN_W-1){1'b0}}};
	assign mag_a = (exp_a == '0) ? '0 : in_a[WORD_W-2:0];
	assign mag_b = (exp_b == '0) ? '0 : in_b[WORD_W-2:0];

	// Exponent above fraction, so one compare orders by magnitude
	assign a_big     = mag_a >= mag_b;
	assign exp_big   = a_big ? exp_a : exp_b;
	assign exp_small = a_big ? exp_b : exp_a;
	assign sig_small = a_big ? sig_b : sig_a;
	assign exp_diff  = exp_big - exp_small;

	always_comb begin
		lost_mask = ~({SIG_W{1'b1}} << exp_diff);
		if (exp_diff >= SIG_W) begin
			sig_shifted = {{(SIG_W-1){1'b0}}, |sig_small};
		end else begin
			sig_shifted = sig_small >> exp_diff;
			sig_shifted[0] = sig_shifted[0] | (|(sig_small & lost_mask));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_sign_big   <= a_big ? in_a[WORD_W-1] : in_b[WORD_W-1];
			out_sign_small <= a_big ? in_b[WORD_W-1] : in_a[WORD_W-1];
			out_exp        <= exp_big;
			out_sig_big    <= a_big ? sig_a : sig_b;
			out_sig_small  <= sig_shifted;
		end
	end

endmodule

/* source/fp_mantissa_add.sv */
`timescale 1ns/1ps

module fp_mantissa_add import fp_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	input  logic             in_sign_big,
	input  logic             in_sign_small,
	input  logic [EXP_W-1:0] in_exp,
	input  logic [SIG_W-1:0] in_sig_big,
	input  logic [SIG_W-1:0] in_sig_small,
	output logic             out_valid,
	output logic             out_sign,
	output logic [EXP_W-1:0] out_exp,
	output logic [SIG_W:0]   out_sum
);

	logic [SIG_W:0] sum;

	// Big minus small never goes negative
	always_comb begin
		if (in_sign_big == in_sign_small) begin
			sum = {1'b0, in_sig_big} + {1'b0, in_sig_small};
		end else begin
			sum = {1'b0, in_sig_big} - {1'b0, in_sig_small};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_sign <= in_sign_big;
			out_exp  <= in_exp;
			out_sum  <= sum;
		end
	end

endmodule

/* source/fp_normalize.sv */
`timescale 1ns/1ps

module fp_normalize import fp_pkg::*; (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	input  logic             in_sign,
	input  logic [EXP_W-1:0] in_exp,
	input  logic [SIG_W:0]   in_sum,
	output logic             out_valid,
	output logic             out_sign,
	output logic [EXP_W-1:0] out_exp,
	output logic [SIG_W-1:0] out_sig,
	output logic             out_zero
);

	localparam int LZ_W = $clog2(SIG_W + 1);

	logic [LZ_W-1:0]  lz;
	logic [SIG_W-1:0] sig_n;
	logic [EXP_W-1:0] exp_n;
	logic             zero_n;

	// Leading zeros below the carry bit, highest set bit wins
	always_comb begin
		lz = LZ_W'(SIG_W);
		for (int i = 0; i < SIG_W; i++) begin
			if (in_sum[i]) begin
				lz = LZ_W'(SIG_W - 1 - i);
			end
		end
	end

	always_comb begin
		if (in_sum[SIG_W]) begin
			// Carry out, fold the dropped bit into sticky
			sig_n  = {in_sum[SIG_W:2], in_sum[1] | in_sum[0]};
			exp_n  = in_exp + 1'b1;
			zero_n = 1'b0;
		end else begin
			sig_n  = in_sum[SIG_W-1:0] << lz;
			exp_n  = in_exp - EXP_W'(lz);
			// Exact zero, or exponent would drop to 0 or below
			zero_n = (in_sum == '0) || (EXP_W'(lz) >= in_exp);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_sign <= in_sign;
			out_exp  <= exp_n;
			out_sig  <= sig_n;
			out_zero <= zero_n;
		end
	end

endmodule

/* source/fp_round.sv */
`timescale 1ns/1ps

module fp_round import fp_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  logic              in_sign,
	input  logic [EXP_W-1:0]  in_exp,
	input  logic [SIG_W-1:0]  in_sig,
	input  logic              in_zero,
	output logic              out_valid,
	output logic [WORD_W-1:0] out_data
);

	logic             round_up;
	logic [MAN_W+1:0] mant;
	logic [MAN_W-1:0] frac;
	logic [EXP_W:0]   exp_r;
	logic [WORD_W-1:0] packed_word;

	// Guard is bit 2, round bit 1, sticky bit 0, result lsb bit 3
	assign round_up = in_sig[2] & (in_sig[1] | in_sig[0] | in_sig[3]);
	assign mant     = {1'b0, in_sig[SIG_W-1:3]} + round_up;

	// Rounding carry leaves 1.000..., so renormalize by one
	assign frac  = mant[MAN_W+1] ? mant[MAN_W:1] : mant[MAN_W-1:0];
	assign exp_r = {1'b0, in_exp} + mant[MAN_W+1];

	always_comb begin
		if (in_zero) begin
			packed_word = '0;
		end else if (exp_r >= EXP_MAX) begin
			packed_word = {in_sign, {EXP_W{1'b1}}, {MAN_W{1'b0}}};
		end else begin
			packed_word = {in_sign, exp_r[EXP_W-1:0], frac};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			out_data <= packed_word;
		end
	end

endmodule

/* source/fp_add_sub.sv */
`timescale 1ns/1ps

module fp_add_sub import fp_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              op_valid,
	input  logic [WORD_W-1:0] op_a,
	input  logic [WORD_W-1:0] op_b,
	input  logic              op_sub,
	output logic              res_valid,
	output logic [WORD_W-1:0] res_data
);

	logic [WORD_W-1:0] b_eff;

	logic             s1_valid;
	logic             s1_sign_big;
	logic             s1_sign_small;
	logic [EXP_W-1:0] s1_exp;
	logic [SIG_W-1:0] s1_sig_big;
	logic [SIG_W-1:0] s1_sig_small;

	logic             s2_valid;
	logic             s2_sign;
	logic [EXP_W-1:0] s2_exp;
	logic [SIG_W:0]   s2_sum;

	logic             s3_valid;
	logic             s3_sign;
	logic [EXP_W-1:0] s3_exp;
	logic [SIG_W-1:0] s3_sig;
	logic             s3_zero;

	// Subtract is add with B negated
	assign b_eff = {op_b[WORD_W-1] ^ op_sub, op_b[WORD_W-2:0]};

	//////////////////////////////////////////////////////////////////////
	// Align, add, normalize, round

	fp_align i_align (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (op_valid),
		.in_a          (op_a),
		.in_b          (b_eff),
		.out_valid     (s1_valid),
		.out_sign_big  (s1_sign_big),
		.out_sign_small(s1_sign_small),
		.out_exp       (s1_exp),
		.out_sig_big   (s1_sig_big),
		.out_sig_small (s1_sig_small)
	);

	fp_mantissa_add i_mantissa_add (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (s1_valid),
		.in_sign_big  (s1_sign_big),
		.in_sign_small(s1_sign_small),
		.in_exp       (s1_exp),
		.in_sig_big   (s1_sig_big),
		.in_sig_small (s1_sig_small),
		.out_valid    (s2_valid),
		.out_sign     (s2_sign),
		.out_exp      (s2_exp),
		.out_sum      (s2_sum)
	);

	fp_normalize i_normalize (
		.clk      (clk),
		.reset    (reset),
		.in_valid (s2_valid),
		.in_sign  (s2_sign),
		.in_exp   (s2_exp),
		.in_sum   (s2_sum),
		.out_valid(s3_valid),
		.out_sign (s3_sign),
		.out_exp  (s3_exp),
		.out_sig  (s3_sig),
		.out_zero (s3_zero)
	);

	fp_round i_round (
		.clk      (clk),
		.reset    (reset),
		.in_valid (s3_valid),
		.in_sign  (s3_sign),
		.in_exp   (s3_exp),
		.in_sig   (s3_sig),
		.in_zero  (s3_zero),
		.out_valid(res_valid),
		.out_data (res_data)
	);

endmodule

/* source/fp_axil_regs.sv */
`timescale 1ns/1ps

module fp_axil_regs import fp_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                awvalid,
	output logic                awready,
	input  logic [ADDR_W-1:0]   awaddr,
	input  logic                wvalid,
	output logic                wready,
	input  logic [WORD_W-1:0]   wdata,
	input  logic [WORD_W/8-1:0] wstrb,
	output logic                bvalid,
	input  logic                bready,
	output logic [1:0]          bresp,
	input  logic                arvalid,
	output logic                arready,
	input  logic [ADDR_W-1:0]   araddr,
	output logic                rvalid,
	input  logic                rready,
	output logic [WORD_W-1:0]   rdata,
	output logic [1:0]          rresp,
	input  logic                res_valid,
	input  logic [WORD_W-1:0]   res_data,
	output logic                op_valid,
	output logic [WORD_W-1:0]   op_a,
	output logic [WORD_W-1:0]   op_b,
	output logic                op_sub
);

	logic              wr_en;
	logic              rd_en;
	logic              busy;
	logic [WORD_W-1:0] result;

	//////////////////////////////////////////////////////////////////////
	// Write channel

	assign wready = awready;
	assign wr_en  = awready && awvalid && wvalid;

	// One-cycle accept pulse, held off while bvalid waits
	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
		end else begin
			awready <= awvalid && wvalid && !bvalid && !awready;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid   <= 1'b0;
			bresp    <= RESP_OKAY;
			op_valid <= 1'b0;
			busy     <= 1'b0;
			result   <= '0;
		end else begin
			op_valid <= 1'b0;
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (res_valid) begin
				result <= res_data;
				busy   <= 1'b0;
			end
			if (wr_en) begin
				bvalid <= 1'b1;
				bresp  <= RESP_OKAY;
				if (awaddr == REG_CTRL) begin
					if (busy) begin
						bresp <= RESP_SLVERR;
					end else begin
						op_valid <= 1'b1;
						busy     <= 1'b1;
					end
				end
			end
		end
	end

	// Operand and opcode storage, result register is read only
	always_ff @(posedge clk) begin
		if (wr_en) begin
			case (awaddr)
				REG_A: op_a <= wdata;
				REG_B: op_b <= wdata;
				REG_CTRL: begin
					if (!busy) begin
						op_sub <= wdata[0];
					end
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read channel

	assign arready = !rvalid;
	assign rd_en   = arvalid && arready;
	assign rresp   = RESP_OKAY;

	always_ff @(posedge clk) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else if (rd_en) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			case (araddr)
				REG_A:      rdata <= op_a;
				REG_B:      rdata <= op_b;
				REG_CTRL:   rdata <= {{(WORD_W-1){1'b0}}, busy};
				REG_RESULT: rdata <= result;
				default:    rdata <= '0;
			endcase
		end
	end

endmodule

/* source/fp_accel_top.sv */
`timescale 1ns/1ps

module fp_accel_top import fp_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                awvalid,
	output logic                awready,
	input  logic [ADDR_W-1:0]   awaddr,
	input  logic                wvalid,
	output logic                wready,
	input  logic [WORD_W-1:0]   wdata,
	input  logic [WORD_W/8-1:0] wstrb,
	output logic                bvalid,
	input  logic                bready,
	output logic [1:0]          bresp,
	input  logic                arvalid,
	output logic                arready,
	input  logic [ADDR_W-1:0]   araddr,
	output logic                rvalid,
	input  logic                rready,
	output logic [WORD_W-1:0]   rdata,
	output logic [1:0]          rresp
);

	logic              op_valid;
	logic [WORD_W-1:0] op_a;
	logic [WORD_W-1:0] op_b;
	logic              op_sub;
	logic              res_valid;
	logic [WORD_W-1:0] res_data;

	fp_axil_regs i_regs (
		.clk      (clk),
		.reset    (reset),
		.awvalid  (awvalid),
		.awready  (awready),
		.awaddr   (awaddr),
		.wvalid   (wvalid),
		.wready   (wready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.bvalid   (bvalid),
		.bready   (bready),
		.bresp    (bresp),
		.arvalid  (arvalid),
		.arready  (arready),
		.araddr   (araddr),
		.rvalid   (rvalid),
		.rready   (rready),
		.rdata    (rdata),
		.rresp    (rresp),
		.res_valid(res_valid),
		.res_data (res_data),
		.op_valid (op_valid),
		.op_a     (op_a),
		.op_b     (op_b),
		.op_sub   (op_sub)
	);

	// Four-cycle add/subtract pipeline
	fp_add_sub i_add_sub (
		.clk      (clk),
		.reset    (reset),
		.op_valid (op_valid),
		.op_a     (op_a),
		.op_b     (op_b),
		.op_sub   (op_sub),
		.res_valid(res_valid),
		.res_data (res_data)
	);

endmodule

/* bench/tb_fp_accel.sv */
`timescale 1ns/1ps

module tb_fp_accel import fp_pkg::*; ();

	// Directed operations plus the random batch
	localparam int N_DIRECTED  = 16;
	localparam int N_RANDOM    = 200;
	localparam int N_OPS       = N_DIRECTED + N_RANDOM;
	localparam int WATCHDOG_NS = N_OPS * 200 + 2000;

	logic                clk;
	logic                reset;
	logic                awvalid;
	logic                awready;
	logic [ADDR_W-1:0]   awaddr;
	logic                wvalid;
	logic                wready;
	logic [WORD_W-1:0]   wdata;
	logic [WORD_W/8-1:0] wstrb;
	logic                bvalid;
	logic                bready;
	logic [1:0]          bresp;
	logic                arvalid;
	logic                arready;
	logic [ADDR_W-1:0]   araddr;
	logic                rvalid;
	logic                rready;
	logic [WORD_W-1:0]   rdata;
	logic [1:0]          rresp;

	fp_accel_top i_dut (
		.clk    (clk),
		.reset  (reset),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr (awaddr),
		.wvalid (wvalid),
		.wready (wready),
		.wdata  (wdata),
		.wstrb  (wstrb),
		.bvalid (bvalid),
		.bready (bready),
		.bresp  (bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr (araddr),
		.rvalid (rvalid),
		.rready (rready),
		.rdata  (rdata),
		.rresp  (rresp)
	);

	initial begin
		clk = 1'b0;
	end

	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Checking and reference model

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "Check on %s failed", name);
		end
	endtask

	// Exact widening to double with exponent zero read as zero
	function automatic real float_to_real(input logic [31:0] f);
		logic [63:0] d;
		if (f[30:23] == 8'd0) begin
			return 0.0;
		end
		d = {f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'd0};
		return $bitstoreal(d);
	endfunction

	// Nearest-even narrowing to single with flush to +0
	function automatic logic [31:0] real_to_float(input real r);
		logic [63:0] d;
		int          exp_s;
		logic        up;
		logic [24:0] rounded;
		d = $realtobits(r);
		if (d[62:52] == 11'd0) begin
			return 32'h0;
		end
		exp_s = int'(d[62:52]) - 896;
		if (exp_s <= 0) begin
			return 32'h0;
		end
		up      = d[28] && ((|d[27:0]) || d[29]);
		rounded = {2'b01, d[51:29]} + {24'd0, up};
		if (rounded[24]) begin
			exp_s++;
		end
		if (exp_s >= EXP_MAX) begin
			return {d[63], 8'hFF, 23'd0};
		end
		return {d[63], 8'(exp_s), rounded[24] ? rounded[23:1] : rounded[22:0]};
	endfunction

	function automatic logic [31:0] expected_result(input logic [31:0] a,
			input logic [31:0] b, input logic sub);
		real ra;
		real rb;
		ra = float_to_real(a);
		rb = float_to_real(b);
		if (sub) begin
			rb = -rb;
		end
		return real_to_float(ra + rb);
	endfunction

	function automatic logic [31:0] random_float(input int exp_lo, input int exp_hi);
		int e;
		e = exp_lo + int'($urandom % 32'(exp_hi - exp_lo + 1));
		return {1'($urandom), 8'(e), 23'($urandom)};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// AXI4-Lite master

	task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= 4'hF;
		bready  <= 1'b1;
		@(negedge clk);
		while (!(awready && wready)) begin
			@(negedge clk);
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		@(negedge clk);
		while (!bvalid) begin
			@(negedge clk);
		end
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		@(posedge clk);
		arvalid <= 1'b1;
		araddr  <= addr;
		rready  <= 1'b1;
		@(negedge clk);
		while (!arready) begin
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		while (!rvalid) begin
			@(negedge clk);
		end
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		logic [1:0]  resp;
		status = 32'h1;
		while (status[0]) begin
			axil_read(REG_CTRL, status, resp);
		end
	endtask

	task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic sub,
			output logic [31:0] result);
		logic [1:0] resp;
		axil_write(REG_A, a, resp);
		axil_write(REG_B, b, resp);
		axil_write(REG_CTRL, {31'd0, sub}, resp);
		check("bresp launch", {30'd0, resp}, {30'd0, RESP_OKAY});
		wait_idle();
		axil_read(REG_RESULT, result, resp);
	endtask

	// Model result plus a hand-worked value
	task automatic arith_case(input string name, input logic [31:0] a,
			input logic [31:0] b, input logic sub, input logic [31:0] known);
		logic [31:0] result;
		run_op(a, b, sub, result);
		check(name, result, expected_result(a, b, sub));
		check({name, " known"}, result, known);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_registers();
		logic [31:0] data;
		logic [1:0]  resp;
		axil_read(REG_CTRL, data, resp);
		check("busy after reset", data, 32'h0);
		check("rresp", {30'd0, resp}, {30'd0, RESP_OKAY});
		axil_write(REG_A, 32'h12345678, resp);
		axil_write(REG_B, 32'h9ABCDEF0, resp);
		axil_read(REG_A, data, resp);
		check("reg A", data, 32'h12345678);
		axil_read(REG_B, data, resp);
		check("reg B", data, 32'h9ABCDEF0);
		// Launch 1.0 + 2.0 and poll busy while it runs
		axil_write(REG_A, 32'h3F800000, resp);
		axil_write(REG_B, 32'h40000000, resp);
		axil_write(REG_CTRL, 32'h0, resp);
		axil_read(REG_CTRL, data, resp);
		check("busy during op", data, 32'h1);
		wait_idle();
		axil_read(REG_RESULT, data, resp);
		check("result before write", data, 32'h40400000);
		axil_write(REG_RESULT, 32'hDEADBEEF, resp);
		check("bresp result write", {30'd0, resp}, {30'd0, RESP_OKAY});
		axil_read(REG_RESULT, data, resp);
		check("result after write", data, 32'h40400000);
	endtask

	task automatic test_arith();
		arith_case("1.0+2.0", 32'h3F800000, 32'h40000000, 1'b0, 32'h40400000);
		arith_case("1.5-1.5", 32'h3FC00000, 32'h3FC00000, 1'b1, 32'h00000000);
		arith_case("-3.25+1.0", 32'hC0500000, 32'h3F800000, 1'b0, 32'hC0100000);
		arith_case("far add", 32'h4F800000, 32'h3F800001, 1'b0, 32'h4F800000);
		arith_case("far sub", 32'h4F800000, 32'h3F800001, 1'b1, 32'h4F800000);
	endtask

	task automatic test_rounding();
		// Halfway cases around 1.0 where one ulp is 2^-23
		arith_case("tie even down", 32'h3F800000, 32'h33800000, 1'b0, 32'h3F800000);
		arith_case("tie even up", 32'h3F800001, 32'h33800000, 1'b0, 32'h3F800002);
		arith_case("round carry", 32'h3FFFFFFF, 32'h33800000, 1'b0, 32'h40000000);
		arith_case("cancellation", 32'h3F800001, 32'h3F800000, 1'b1, 32'h34000000);
	endtask

	task automatic test_range();
		arith_case("overflow pos", 32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, 32'h7F800000);
		arith_case("overflow neg", 32'hFF7FFFFF, 32'hFF7FFFFF, 1'b0, 32'hFF800000);
		arith_case("underflow", 32'h00800001, 32'h00800000, 1'b1, 32'h00000000);
		// A kept subnormal would change the smallest normal
		arith_case("subnormal in", 32'h00400000, 32'h00800000, 1'b0, 32'h00800000);
		arith_case("two subnormals", 32'h80400000, 32'h80400000, 1'b0, 32'h00000000);
	endtask

	task automatic test_busy();
		logic [31:0] result;
		logic [1:0]  resp;
		axil_write(REG_A, 32'h40400000, resp);
		axil_write(REG_B, 32'h3F800000, resp);
		axil_write(REG_CTRL, 32'h1, resp);
		check("bresp first launch", {30'd0, resp}, {30'd0, RESP_OKAY});
		axil_write(REG_CTRL, 32'h0, resp);
		check("bresp busy launch", {30'd0, resp}, {30'd0, RESP_SLVERR});
		wait_idle();
		axil_read(REG_RESULT, result, resp);
		check("result under busy", result,
			expected_result(32'h40400000, 32'h3F800000, 1'b1));
		check("result under busy known", result, 32'h40000000);
	endtask

	task automatic test_random();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] result;
		logic        sub;
		int          ea;
		for (int i = 0; i < N_RANDOM; i++) begin
			a   = random_float(1, 254);
			sub = 1'($urandom);
			ea  = int'(a[30:23]);
			// Every other case keeps exponents close so cancellation shows up
			if (i % 2 == 1) begin
				b = random_float((ea > 4) ? ea - 3 : 1, (ea < 251) ? ea + 3 : 254);
			end else begin
				b = random_float(1, 254);
			end
			run_op(a, b, sub, result);
			check($sformatf("random %0d", i), result, expected_result(a, b, sub));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		void'($urandom(32'h6de2d9c8));
		reset    = 1'b1;
		awvalid  = 1'b0;
		awaddr   = '0;
		wvalid   = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		bready   = 1'b0;
		arvalid  = 1'b0;
		araddr   = '0;
		rready   = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		test_registers();
		test_arith();
		test_rounding();
		test_range();
		test_busy();
		test_random();

		$display("TEST PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("TEST FAILED");
		$fatal(1, "Timeout");
	end

endmodule

/* fp_accel.f */
source/fp_pkg.sv
source/fp_align.sv
source/fp_mantissa_add.sv
source/fp_normalize.sv
source/fp_round.sv
source/fp_add_sub.sv
source/fp_axil_regs.sv
source/fp_accel_top.sv
bench/tb_fp_accel.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -j 0 \
	--top-module tb_fp_accel \
	-f fp_accel.f \
	-o Vtb_fp_accel

# The log decides the outcome, so a fatal exit must not stop the script here
./obj_dir/Vtb_fp_accel > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
